/* verilog.f */
design/mipsPkg.sv
design/alu.sv
design/regFile.sv
design/hazardUnit.sv
design/controller.sv
design/datapath.sv
design/mipsCore.sv
tests/mipsCoreTb_chk.sv
tests/mipsCoreTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the mipsCore testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --assert --timing --top-module mipsCoreTb -f verilog.f -Mdir "$buildDir"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$buildDir/VmipsCoreTb" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "^Testbench passed$" "$logFile"; then
	exit 0
fi
echo "pass message not found in $logFile"
exit 1

/* tests/mipsCoreTb.sv */
`default_nettype none
`timescale 1ns/100ps

module mipsCoreTb;
	import mipsPkg::*;

	localparam word_t resetPc = 32'h0000_0100;
	// word index of the first fetch
	localparam int progBase = int'(resetPc >> 2);

	logic  clk = 1'b0;
	logic  rstN;
	word_t instrF;
	word_t pcF;
	logic  memWriteM;
	word_t aluOutM;
	word_t writeDataM;
	word_t readDataM;

	// memory models and store log
	word_t instrMem [256];
	word_t dataMem [64];
	word_t prog [$];
	word_t logAddr [$];
	word_t logData [$];
	word_t expAddr [$];
	word_t expData [$];

	logic        wrPending = 1'b0;
	word_t       wrAddr;
	word_t       wrData;
	int          cycleCount = 0;
	int          loadedWords = 0;
	logic [31:0] lfsrState;

	mipsCore #(
		.resetPc (resetPc)
	) dut_i (
		.clk        (clk),
		.rstN       (rstN),
		.instrF     (instrF),
		.pcF        (pcF),
		.memWriteM  (memWriteM),
		.aluOutM    (aluOutM),
		.writeDataM (writeDataM),
		.readDataM  (readDataM)
	);

	always #10 clk = ~clk;

	// ====================
	// memory side
	// ====================
	// store request sampled mid cycle
	always @(negedge clk) begin
		wrPending = memWriteM && rstN;
		wrAddr = aluOutM;
		wrData = writeDataM;
	end

	// write on the rising edge then refresh both read ports
	always @(posedge clk) begin
		if (wrPending && rstN) begin
			dataMem[wrAddr[7:2]] = wrData;
			logAddr.push_back(wrAddr);
			logData.push_back(wrData);
		end
		#2;
		instrF = instrMem[pcF[9:2]];
		readDataM = dataMem[aluOutM[7:2]];
	end

	// watchdog at 8 cycles per loaded instruction plus margin
	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount > 8 * loadedWords + 100) begin
			$display("Timeout after %0d cycles, expected stores never arrived", cycleCount);
			abortRun();
		end
	end

	// bound datapath assertions
	always @(negedge clk) begin
		if (dut_i.uDatapath.chk_i.failCount != 0) begin
			$display("Bound assertion on the datapath failed");
			abortRun();
		end
	end

	task automatic abortRun();
		$display("Testbench failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkWord(input string name, input word_t got, input word_t exp);
		assert (got === exp) else begin
			$display("CHECK FAILED: %s got 0x%08h expected 0x%08h", name, got, exp);
			abortRun();
		end
	endtask

	// ====================
	// assembler helpers
	// ====================
	function automatic word_t rTypeInstr(opcode_t funct, regAddr_t rd, regAddr_t rs,
		regAddr_t rt);
		return {opRType, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic word_t iTypeInstr(opcode_t op, regAddr_t rs, regAddr_t rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// pseudo-direct target, low 28 bits only
	function automatic word_t jumpInstr(word_t target);
		return {opJ, target[27:2]};
	endfunction

	function automatic word_t progAddr(int idx);
		return resetPc + word_t'(4 * idx);
	endfunction

	// offset counts from the delay slot
	function automatic logic [15:0] branchOff(int from, int to);
		return 16'(to - from - 1);
	endfunction

	// jump onto itself with a nop in the slot
	task automatic appendHalt();
		prog.push_back(jumpInstr(progAddr(prog.size())));
	endtask

	task automatic expectStore(input word_t addr, input word_t data);
		expAddr.push_back(addr);
		expData.push_back(data);
	endtask

	// galois form with taps at 32, 22, 2 and 1
	function automatic logic [31:0] galoisStep(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	task automatic takeRandom16(output logic [15:0] v);
		v = '0;
		for (int i = 0; i < 16; i++) begin
			v = {v[14:0], lfsrState[0]};
			lfsrState = galoisStep(lfsrState);
		end
	endtask

	// ====================
	// run control
	// ====================
	task automatic loadProgram();
		foreach (instrMem[i])
			instrMem[i] = '0;
		foreach (prog[i])
			instrMem[8'(progBase + i)] = prog[i];
		loadedWords += prog.size();
		logAddr.delete();
		logData.delete();
	endtask

	// 4 cycles of reset with pc and store strobe checked each cycle
	task automatic resetCore();
		@(posedge clk);
		#2 rstN = 1'b0;
		repeat (4) begin
			@(negedge clk);
			checkWord("pcF in reset", pcF, resetPc);
			checkWord("memWriteM in reset", word_t'(memWriteM), '0);
		end
		@(posedge clk);
		#2 rstN = 1'b1;
	endtask

	task automatic runProgram(input string testName);
		loadProgram();
		resetCore();
		// store count is the done condition
		while (logAddr.size() < expAddr.size())
			@(negedge clk);
		// stray stores would show up here
		repeat (4) @(negedge clk);
		checkWord({testName, " store count"}, word_t'(logAddr.size()), word_t'(expAddr.size()));
		foreach (expAddr[i]) begin
			checkWord($sformatf("%s aluOutM of store %0d", testName, i), logAddr[i], expAddr[i]);
			checkWord($sformatf("%s writeDataM of store %0d", testName, i), logData[i], expData[i]);
		end
		prog.delete();
		expAddr.delete();
		expData.delete();
	endtask

	// ====================
	// directed tests
	// ====================
	task automatic resetState();
		appendHalt();
		loadProgram();
		resetCore();
		@(negedge clk);
		checkWord("pcF after reset", pcF, resetPc);
		repeat (3) begin
			checkWord("memWriteM after reset", word_t'(memWriteM), '0);
			@(negedge clk);
		end
		prog.delete();
	endtask

	// each op reads the one before through memory and writeback forwarding
	task automatic aluChain();
		word_t v1;
		word_t v2;
		word_t v3;
		word_t v4;
		word_t v5;
		word_t v6;
		v1 = 32'h0000_0037;
		v2 = v1 + v1;
		v3 = v2 - v1;
		v4 = v3 & v2;
		v5 = v4 | v3;
		v6 = ($signed(v4) < $signed(v5)) ? 32'd1 : 32'd0;
		prog.push_back(iTypeInstr(opAddi, 5'd0, 5'd1, 16'h0037));
		prog.push_back(rTypeInstr(functAdd, 5'd2, 5'd1, 5'd1));
		prog.push_back(rTypeInstr(functSub, 5'd3, 5'd2, 5'd1));
		prog.push_back(rTypeInstr(functAnd, 5'd4, 5'd3, 5'd2));
		prog.push_back(rTypeInstr(functOr, 5'd5, 5'd4, 5'd3));
		prog.push_back(rTypeInstr(functSlt, 5'd6, 5'd4, 5'd5));
		// results of $2 to $6 at consecutive words
		for (int r = 2; r <= 6; r++)
			prog.push_back(iTypeInstr(opSw, 5'd0, 5'(r), 16'(4 * (r - 2))));
		appendHalt();
		expectStore(32'd0, v2);
		expectStore(32'd4, v3);
		expectStore(32'd8, v4);
		expectStore(32'd12, v5);
		expectStore(32'd16, v6);
		runProgram("aluChain");
	endtask

	task automatic loadThenUse();
		prog.push_back(iTypeInstr(opAddi, 5'd0, 5'd1, 16'h1234));
		prog.push_back(iTypeInstr(opAddi, 5'd0, 5'd4, 16'hfffb));
		prog.push_back(iTypeInstr(opSw, 5'd0, 5'd1, 16'd32));
		prog.push_back(iTypeInstr(opLw, 5'd0, 5'd2, 16'd32));
		// user right behind the load
		prog.push_back(rTypeInstr(functAdd, 5'd3, 5'd2, 5'd4));
		prog.push_back(iTypeInstr(opSw, 5'd0, 5'd3, 16'd36));
		appendHalt();
		expectStore(32'd32, 32'h0000_1234);
		// addend is -5 after sign extension
		expectStore(32'd36, 32'h0000_1234 + 32'hffff_fffb);
		runProgram("loadUse");
	endtask

	task automatic branchesWithSlots();
		prog.push_back(iTypeInstr(opAddi, 5'd0, 5'd1, 16'd7));
		prog.push_back(iTypeInstr(opAddi, 5'd0, 5'd2, 16'd7));
		// index 2 taken with $2 from the line before
		prog.push_back(iTypeInstr(opBeq, 5'd1, 5'd2, branchOff(2, 5)));
		prog.push_back(iTypeInstr(opAddi, 5'd0, 5'd3, 16'h0011));
		// skipped marker
		prog.push_back(iTypeInstr(opSw, 5'd0, 5'd1, 16'd64));
		prog.push_back(iTypeInstr(opSw, 5'd0, 5'd3, 16'd68));
		// index 6 not taken
		prog.push_back(iTypeInstr(opBeq, 5'd1, 5'd3, branchOff(6, 9)));
		prog.push_back(iTypeInstr(opAddi, 5'd0, 5'd4, 16'h0022));
		prog.push_back(iTypeInstr(opSw, 5'd0, 5'd4, 16'd72));
		prog.push_back(iTypeInstr(opAddi, 5'd0, 5'd5, 16'h0022));
		// index 10 taken while $5 is still in execute
		prog.push_back(iTypeInstr(opBeq, 5'd5, 5'd4, branchOff(10, 13)));
		prog.push_back(iTypeInstr(opAddi, 5'd0, 5'd6, 16'h0033));
		prog.push_back(iTypeInstr(opSw, 5'd0, 5'd1, 16'd76));
		prog.push_back(iTypeInstr(opSw, 5'd0, 5'd6, 16'd80));
		prog.push_back(iTypeInstr(opSw, 5'd0, 5'd5, 16'd84));
		appendHalt();
		expectStore(32'd68, 32'h11);
		expectStore(32'd72, 32'h22);
		expectStore(32'd80, 32'h33);
		expectStore(32'd84, 32'h22);
		runProgram("branches");
	endtask

	task automatic jumpOverMarker();
		prog.push_back(iTypeInstr(opAddi, 5'd0, 5'd1, 16'h0044));
		prog.push_back(jumpInstr(progAddr(4)));
		// delay slot
		prog.push_back(iTypeInstr(opAddi, 5'd0, 5'd2, 16'h0055));
		prog.push_back(iTypeInstr(opSw, 5'd0, 5'd1, 16'd88));
		prog.push_back(iTypeInstr(opSw, 5'd0, 5'd2, 16'd92));
		prog.push_back(iTypeInstr(opSw, 5'd0, 5'd1, 16'd96));
		appendHalt();
		expectStore(32'd92, 32'h55);
		expectStore(32'd96, 32'h44);
		runProgram("jump");
	endtask

	// ten lfsr pairs through add, sub and slt
	task automatic randomOperands();
		logic [15:0] a;
		logic [15:0] b;
		word_t       sa;
		word_t       sb;
		for (int k = 0; k < 10; k++) begin
			takeRandom16(a);
			takeRandom16(b);
			// addi sign extends its immediate
			sa = {{16{a[15]}}, a};
			sb = {{16{b[15]}}, b};
			prog.push_back(iTypeInstr(opAddi, 5'd0, 5'd1, a));
			prog.push_back(iTypeInstr(opAddi, 5'd0, 5'd2, b));
			prog.push_back(rTypeInstr(functAdd, 5'd3, 5'd1, 5'd2));
			prog.push_back(rTypeInstr(functSub, 5'd4, 5'd1, 5'd2));
			prog.push_back(rTypeInstr(functSlt, 5'd5, 5'd1, 5'd2));
			prog.push_back(iTypeInstr(opSw, 5'd0, 5'd3, 16'(12 * k)));
			prog.push_back(iTypeInstr(opSw, 5'd0, 5'd4, 16'(12 * k + 4)));
			prog.push_back(iTypeInstr(opSw, 5'd0, 5'd5, 16'(12 * k + 8)));
			expectStore(word_t'(12 * k), sa + sb);
			expectStore(word_t'(12 * k + 4), sa - sb);
			expectStore(word_t'(12 * k + 8), ($signed(sa) < $signed(sb)) ? 32'd1 : 32'd0);
		end
		appendHalt();
		runProgram("random");
	endtask

	initial begin
		rstN = 1'b0;
		instrF = '0;
		readDataM = '0;
		lfsrState = 32'h7237_684a;
		resetState();
		aluChain();
		loadThenUse();
		branchesWithSlots();
		jumpOverMarker();
		randomOperands();
		if (dut_i.uDatapath.chk_i.failCount == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("Bound assertion on the datapath failed");
			abortRun();
		end
	end

endmodule

`default_nettype wire

/* tests/mipsCoreTb_chk.sv */
`default_nettype none
`timescale 1ns/100ps

module datapathChk (
	input logic              clk,
	input logic              rstN,
	input mipsPkg::word_t    pcF,
	input logic              stallD,
	input logic              flushE,
	input logic              memWrite,
	input logic              regWriteW,
	input mipsPkg::regAddr_t writeRegW
);

	// failed assertions so far, watched by the testbench
	int failCount = 0;

	// ====================
	// pipeline rules
	// ====================
	// fetch address stays on a word boundary
	pcAligned: assert property (@(posedge clk) disable iff (!rstN)
		pcF[1:0] == 2'b00)
		else begin
			failCount++;
			$error("pcF is not word aligned");
		end

	// bubble goes in whenever decode holds
	flushFollowsStall: assert property (@(posedge clk) disable iff (!rstN)
		flushE == stallD)
		else begin
			failCount++;
			$error("flushE differs from stallD");
		end

	// store strobe always resolved
	storeKnown: assert property (@(posedge clk) disable iff (!rstN)
		!$isunknown(memWrite))
		else begin
			failCount++;
			$error("memWriteM is unknown");
		end

	// $0 is never a writeback target
	noRegZeroWrite: assert property (@(posedge clk) disable iff (!rstN)
		!(regWriteW && writeRegW == '0))
		else begin
			failCount++;
			$error("register 0 written in writeback");
		end

endmodule

bind datapath datapathChk chk_i (
	.clk       (clk),
	.rstN      (rstN),
	.pcF       (pcF),
	.stallD    (stallD),
	.flushE    (flushE),
	.memWrite  (ctrlM.memWrite),
	.regWriteW (ctrlW.regWrite),
	.writeRegW (writeRegW)
);

`default_nettype wire

/* design/mipsCore.sv */
`default_nettype none
`timescale 1ns/100ps

module mipsCore #(
	parameter mipsPkg::word_t resetPc = '0
) (
	input  logic           clk,
	input  logic           rstN,
	// fetch port
	input  mipsPkg::word_t instrF,
	output mipsPkg::word_t pcF,
	// data port
	output logic           memWriteM,
	output mipsPkg::word_t aluOutM,
	output mipsPkg::word_t writeDataM,
	input  mipsPkg::word_t readDataM
);
	import mipsPkg::*;

	opcode_t   opD;
	opcode_t   functD;
	logic      equalD;
	logic      pcSrcD;
	logic      jumpD;
	logic      branchD;
	logic      flushE;
	ctrlSigs_t ctrlE;
	ctrlSigs_t ctrlM;
	ctrlSigs_t ctrlW;

	// store strobe straight from the memory stage control word
	assign memWriteM = ctrlM.memWrite;

	controller uController (
		.clk     (clk),
		.rstN    (rstN),
		.opD     (opD),
		.functD  (functD),
		.equalD  (equalD),
		.flushE  (flushE),
		.pcSrcD  (pcSrcD),
		.jumpD   (jumpD),
		.branchD (branchD),
		.ctrlE   (ctrlE),
		.ctrlM   (ctrlM),
		.ctrlW   (ctrlW)
	);

	datapath #(
		.resetPc (resetPc)
	) uDatapath (
		.clk        (clk),
		.rstN       (rstN),
		.instrF     (instrF),
		.pcF        (pcF),
		.pcSrcD     (pcSrcD),
		.jumpD      (jumpD),
		.branchD    (branchD),
		.opD        (opD),
		.functD     (functD),
		.equalD     (equalD),
		.ctrlE      (ctrlE),
		.ctrlM      (ctrlM),
		.ctrlW      (ctrlW),
		.flushE     (flushE),
		.aluOutM    (aluOutM),
		.writeDataM (writeDataM),
		.readDataM  (readDataM)
	);

endmodule

`default_nettype wire

/* design/datapath.sv */
`default_nettype none
`timescale 1ns/100ps

module datapath #(
	parameter mipsPkg::word_t resetPc = '0
) (
	input  logic               clk,
	input  logic               rstN,
	// fetch
	input  mipsPkg::word_t     instrF,
	output mipsPkg::word_t     pcF,
	// decode
	input  logic               pcSrcD,
	input  logic               jumpD,
	input  logic               branchD,
	output mipsPkg::opcode_t   opD,
	output mipsPkg::opcode_t   functD,
	output logic               equalD,
	// control of the later stages
	input  mipsPkg::ctrlSigs_t ctrlE,
	input  mipsPkg::ctrlSigs_t ctrlM,
	input  mipsPkg::ctrlSigs_t ctrlW,
	output logic               flushE,
	// data port
	output mipsPkg::word_t     aluOutM,
	output mipsPkg::word_t     writeDataM,
	input  mipsPkg::word_t     readDataM
);
	import mipsPkg::*;

	// pipeline register groups
	typedef struct packed {
		word_t instr;
		word_t pcPlus4;
	} fetchDecode_t;
	typedef struct packed {
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t rd;
		word_t    srcA;
		word_t    srcB;
		word_t    signImm;
	} decodeExec_t;
	typedef struct packed {
		word_t    aluOut;
		word_t    writeData;
		regAddr_t writeReg;
	} execMem_t;
	typedef struct packed {
		word_t    aluOut;
		word_t    readData;
		regAddr_t writeReg;
	} memWb_t;

	fetchDecode_t fdQ;
	decodeExec_t  deQ;
	execMem_t     emQ;
	memWb_t       mwQ;

	logic     stallF;
	logic     stallD;
	logic     forwardAD;
	logic     forwardBD;
	fwdSel_t  forwardAE;
	fwdSel_t  forwardBE;
	word_t    pcPlus4F;
	word_t    pcNextF;
	word_t    signImmD;
	word_t    pcBranchD;
	word_t    rfDataA;
	word_t    rfDataB;
	word_t    fwdValM;
	word_t    cmpA;
	word_t    cmpB;
	word_t    srcAE;
	word_t    srcBE;
	word_t    aluBE;
	word_t    aluOutE;
	word_t    resultW;
	regAddr_t rsD;
	regAddr_t rtD;
	regAddr_t rdD;
	regAddr_t writeRegE;
	regAddr_t writeRegM;
	regAddr_t writeRegW;

	// ====================
	// fetch
	// ====================
	assign pcPlus4F = pcF + 32'd4;
	// jump over branch, otherwise sequential
	assign pcNextF = jumpD ? {fdQ.pcPlus4[31:28], fdQ.instr[25:0], 2'b00} :
		(pcSrcD ? pcBranchD : pcPlus4F);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			pcF <= resetPc;
		else if (!stallF)
			pcF <= pcNextF;
	end

	// delay slot, never flushed
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			fdQ <= '0;
		else if (!stallD)
			fdQ <= '{instr: instrF, pcPlus4: pcPlus4F};
	end

	// ====================
	// decode
	// ====================
	assign opD = fdQ.instr[31:26];
	assign functD = fdQ.instr[5:0];
	assign rsD = fdQ.instr[25:21];
	assign rtD = fdQ.instr[20:16];
	assign rdD = fdQ.instr[15:11];
	assign signImmD = {{16{fdQ.instr[15]}}, fdQ.instr[15:0]};
	// target relative to the delay slot
	assign pcBranchD = fdQ.pcPlus4 + {signImmD[29:0], 2'b00};

	regFile uRegFile (
		.clk         (clk),
		.rstN        (rstN),
		.writeEnable (ctrlW.regWrite),
		.readAddrA   (rsD),
		.readAddrB   (rtD),
		.writeAddr   (writeRegW),
		.writeData   (resultW),
		.readDataA   (rfDataA),
		.readDataB   (rfDataB)
	);

	// memory stage result, load data is ready combinationally
	assign fwdValM = ctrlM.memToReg ? readDataM : aluOutM;
	assign cmpA = forwardAD ? fwdValM : rfDataA;
	assign cmpB = forwardBD ? fwdValM : rfDataB;
	assign equalD = (cmpA == cmpB);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			deQ <= '0;
		else if (flushE)
			deQ <= '0;
		else
			deQ <= '{rs: rsD, rt: rtD, rd: rdD, srcA: rfDataA, srcB: rfDataB,
				signImm: signImmD};
	end

	// ====================
	// execute
	// ====================
	assign srcAE = (forwardAE == fwdMem) ? aluOutM :
		(forwardAE == fwdWb) ? resultW : deQ.srcA;
	assign srcBE = (forwardBE == fwdMem) ? aluOutM :
		(forwardBE == fwdWb) ? resultW : deQ.srcB;
	assign aluBE = ctrlE.aluSrc ? deQ.signImm : srcBE;
	// rd for r-type, rt for loads and addi
	assign writeRegE = ctrlE.regDst ? deQ.rd : deQ.rt;

	alu uAlu (
		.a       (srcAE),
		.b       (aluBE),
		.aluCtrl (ctrlE.aluCtrl),
		.y       (aluOutE)
	);

	// ====================
	// memory and writeback
	// ====================
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			emQ <= '0;
			mwQ <= '0;
		end else begin
			emQ <= '{aluOut: aluOutE, writeData: srcBE, writeReg: writeRegE};
			mwQ <= '{aluOut: emQ.aluOut, readData: readDataM, writeReg: emQ.writeReg};
		end
	end

	assign aluOutM = emQ.aluOut;
	assign writeDataM = emQ.writeData;
	assign writeRegM = emQ.writeReg;
	assign writeRegW = mwQ.writeReg;
	assign resultW = ctrlW.memToReg ? mwQ.readData : mwQ.aluOut;

	hazardUnit uHazard (
		.rsD       (rsD),
		.rtD       (rtD),
		.rsE       (deQ.rs),
		.rtE       (deQ.rt),
		.writeRegE (writeRegE),
		.writeRegM (writeRegM),
		.writeRegW (writeRegW),
		.regWriteE (ctrlE.regWrite),
		.regWriteM (ctrlM.regWrite),
		.regWriteW (ctrlW.regWrite),
		.memToRegE (ctrlE.memToReg),
		.memToRegM (ctrlM.memToReg),
		.branchD   (branchD),
		.forwardAD (forwardAD),
		.forwardBD (forwardBD),
		.forwardAE (forwardAE),
		.forwardBE (forwardBE),
		.stallF    (stallF),
		.stallD    (stallD),
		.flushE    (flushE)
	);

endmodule

`default_nettype wire

/* design/controller.sv */
`default_nettype none
`timescale 1ns/100ps

module controller (
	input  logic                clk,
	input  logic                rstN,
	input  mipsPkg::opcode_t    opD,
	input  mipsPkg::opcode_t    functD,
	input  logic                equalD,
	input  logic                flushE,
	output logic                pcSrcD,
	output logic                jumpD,
	output logic                branchD,
	output mipsPkg::ctrlSigs_t  ctrlE,
	output mipsPkg::ctrlSigs_t  ctrlM,
	output mipsPkg::ctrlSigs_t  ctrlW
);
	import mipsPkg::*;

	// alu op from main decoder to alu decoder
	localparam logic [1:0] aluOpAdd   = 2'b00;
	localparam logic [1:0] aluOpSub   = 2'b01;
	localparam logic [1:0] aluOpFunct = 2'b10;

	logic       regWriteD;
	logic       memToRegD;
	logic       memWriteD;
	logic       aluSrcD;
	logic       regDstD;
	logic [1:0] aluOpD;
	logic       functOkD;
	aluCtrl_t   aluCtrlD;
	ctrlSigs_t  ctrlD;

	// ====================
	// main decoder
	// ====================
	always_comb begin
		{regWriteD, memToRegD, memWriteD, aluSrcD, regDstD} = '0;
		{branchD, jumpD} = '0;
		aluOpD = aluOpAdd;
		case (opD)
			opRType: begin
				regWriteD = 1'b1;
				regDstD = 1'b1;
				aluOpD = aluOpFunct;
			end
			opLw: begin
				regWriteD = 1'b1;
				memToRegD = 1'b1;
				aluSrcD = 1'b1;
			end
			opSw: begin
				memWriteD = 1'b1;
				aluSrcD = 1'b1;
			end
			opBeq: begin
				branchD = 1'b1;
				aluOpD = aluOpSub;
			end
			opAddi: begin
				regWriteD = 1'b1;
				aluSrcD = 1'b1;
			end
			opJ:
				jumpD = 1'b1;
			default: ;
		endcase
	end

	// ====================
	// alu decoder
	// ====================
	always_comb begin
		functOkD = 1'b1;
		case (aluOpD)
			aluOpAdd:
				aluCtrlD = aluAdd;
			aluOpSub:
				aluCtrlD = aluSub;
			default: begin
				case (functD)
					functAdd: aluCtrlD = aluAdd;
					functSub: aluCtrlD = aluSub;
					functAnd: aluCtrlD = aluAnd;
					functOr:  aluCtrlD = aluOr;
					functSlt: aluCtrlD = aluSlt;
					default: begin
						// sll zero and the rest of r-type, a no-op
						aluCtrlD = aluAdd;
						functOkD = 1'b0;
					end
				endcase
			end
		endcase
	end

	// unknown funct never writes the register file
	assign ctrlD = '{
		regWrite: regWriteD & functOkD,
		memToReg: memToRegD,
		memWrite: memWriteD,
		aluSrc:   aluSrcD,
		regDst:   regDstD,
		aluCtrl:  aluCtrlD
	};

	// branch decided in decode
	assign pcSrcD = branchD & equalD;

	// stage registers, execute takes a bubble on flush
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ctrlE <= '0;
			ctrlM <= '0;
			ctrlW <= '0;
		end else begin
			ctrlE <= flushE ? '0 : ctrlD;
			ctrlM <= ctrlE;
			ctrlW <= ctrlM;
		end
	end

endmodule

`default_nettype wire

/* design/hazardUnit.sv */
`default_nettype none
`timescale 1ns/100ps

module hazardUnit (
	input  mipsPkg::regAddr_t rsD,
	input  mipsPkg::regAddr_t rtD,
	input  mipsPkg::regAddr_t rsE,
	input  mipsPkg::regAddr_t rtE,
	input  mipsPkg::regAddr_t writeRegE,
	input  mipsPkg::regAddr_t writeRegM,
	input  mipsPkg::regAddr_t writeRegW,
	input  logic              regWriteE,
	input  logic              regWriteM,
	input  logic              regWriteW,
	input  logic              memToRegE,
	input  logic              memToRegM,
	input  logic              branchD,
	output logic              forwardAD,
	output logic              forwardBD,
	output mipsPkg::fwdSel_t  forwardAE,
	output mipsPkg::fwdSel_t  forwardBE,
	output logic              stallF,
	output logic              stallD,
	output logic              flushE
);
	import mipsPkg::*;

	logic lwStall;
	logic branchStall;

	// memory stage wins over writeback, $0 never forwarded
	// a load in memory has no alu result to give
	function automatic fwdSel_t execFwd(regAddr_t src);
		if (src != '0 && src == writeRegM && regWriteM && !memToRegM)
			return fwdMem;
		else if (src != '0 && src == writeRegW && regWriteW)
			return fwdWb;
		else
			return fwdReg;
	endfunction

	// ====================
	// forwarding
	// ====================
	always_comb begin
		forwardAE = execFwd(rsE);
		forwardBE = execFwd(rtE);
	end

	// decode comparator takes the memory stage result
	assign forwardAD = (rsD != '0) && (rsD == writeRegM) && regWriteM;
	assign forwardBD = (rtD != '0) && (rtD == writeRegM) && regWriteM;

	// ====================
	// stalls
	// ====================
	// load in execute feeding the next instruction
	assign lwStall = memToRegE && ((rtE == rsD) || (rtE == rtD));

	// beq operand still being computed in execute
	assign branchStall = branchD && regWriteE && (writeRegE != '0) &&
		((writeRegE == rsD) || (writeRegE == rtD));

	assign stallD = lwStall | branchStall;
	assign stallF = stallD;
	// bubble into execute while decode holds
	assign flushE = stallD;

endmodule

`default_nettype wire

/* design/regFile.sv */
`default_nettype none
`timescale 1ns/100ps

module regFile (
	input  logic              clk,
	input  logic              rstN,
	input  logic              writeEnable,
	input  mipsPkg::regAddr_t readAddrA,
	input  mipsPkg::regAddr_t readAddrB,
	input  mipsPkg::regAddr_t writeAddr,
	input  mipsPkg::word_t    writeData,
	output mipsPkg::word_t    readDataA,
	output mipsPkg::word_t    readDataB
);
	import mipsPkg::*;

	word_t regs [32];

	// falling edge write, decode reads the new value in the same cycle
	always_ff @(negedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (writeEnable && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// $0 hardwired to zero
	assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

/* design/alu.sv */
`default_nettype none
`timescale 1ns/100ps

module alu (
	input  mipsPkg::word_t    a,
	input  mipsPkg::word_t    b,
	input  mipsPkg::aluCtrl_t aluCtrl,
	output mipsPkg::word_t    y
);
	import mipsPkg::*;

	always_comb begin
		case (aluCtrl)
			aluAnd: y = a & b;
			aluOr:  y = a | b;
			aluAdd: y = a + b;
			aluSub: y = a - b;
			// signed compare
			aluSlt: y = {31'b0, $signed(a) < $signed(b)};
			default: y = '0;
		endcase
	end

endmodule

`default_nettype wire

/* design/mipsPkg.sv */
`default_nettype none

package mipsPkg;

	// ====================
	// widths
	// ====================
	// data word and byte address
	typedef logic [31:0] word_t;
	// register index
	typedef logic [4:0] regAddr_t;
	// op and funct fields
	typedef logic [5:0] opcode_t;
	typedef logic [2:0] aluCtrl_t;
	// execute operand source
	typedef logic [1:0] fwdSel_t;

	// alu operations
	localparam aluCtrl_t aluAnd = 3'b000;
	localparam aluCtrl_t aluOr  = 3'b001;
	localparam aluCtrl_t aluAdd = 3'b010;
	localparam aluCtrl_t aluSub = 3'b110;
	localparam aluCtrl_t aluSlt = 3'b111;

	// operand sources for the execute muxes
	localparam fwdSel_t fwdReg = 2'b00;
	localparam fwdSel_t fwdWb  = 2'b01;
	localparam fwdSel_t fwdMem = 2'b10;

	// control word, one copy per stage
	typedef struct packed {
		logic     regWrite;
		logic     memToReg;
		logic     memWrite;
		logic     aluSrc;
		logic     regDst;
		aluCtrl_t aluCtrl;
	} ctrlSigs_t;

	// ====================
	// encodings
	// ====================
	localparam opcode_t opRType = 6'b000000;
	localparam opcode_t opLw    = 6'b100011;
	localparam opcode_t opSw    = 6'b101011;
	localparam opcode_t opBeq   = 6'b000100;
	localparam opcode_t opAddi  = 6'b001000;
	localparam opcode_t opJ     = 6'b000010;

	// funct field of r-type
	localparam opcode_t functAdd = 6'b100000;
	localparam opcode_t functSub = 6'b100010;
	localparam opcode_t functAnd = 6'b100100;
	localparam opcode_t functOr  = 6'b100101;
	localparam opcode_t functSlt = 6'b101010;

endpackage

`default_nettype wire
